// File: hw/decode_pkg.sv
/*
  Shared types for the decode stage. Field order in the structs is the
  bit order on the wires, MSB first; the testbench data file follows it.
  Instruction layout is fixed, offset overlaps the second source field.
*/

package decode_pkg;

  // Datapath and register file sizing
  localparam int WORD_W   = 32;
  localparam int NUM_REGS = 32;
  localparam int IDX_W    = $clog2(NUM_REGS);
  localparam int OFF_W    = 15;
  localparam int OPC_W    = 7;

  // Plain vector types with a meaning
  typedef logic [WORD_W-1:0]       word_t;
  typedef logic [IDX_W-1:0]        reg_idx_t;
  typedef logic signed [OFF_W-1:0] offset_t;
  typedef logic [1:0]              alu_op_t;

  // Register that always reads as zero
  localparam reg_idx_t ZERO_REG = '0;

  // Low bit of each instruction field
  localparam int OPC_LSB  = 25;
  localparam int DST_LSB  = 20;
  localparam int SRC1_LSB = 15;
  localparam int SRC2_LSB = 10;

  // ALU selector codes, 2'b11 is pass-b and no opcode here uses it
  localparam alu_op_t ALU_ADD = 2'b00;
  localparam alu_op_t ALU_SUB = 2'b01;
  localparam alu_op_t ALU_MUL = 2'b10;

  // Opcodes, anything else decodes as illegal
  typedef enum logic [OPC_W-1:0] {
    OP_ADD  = 7'h00,
    OP_SUB  = 7'h01,
    OP_MUL  = 7'h02,
    OP_LDW  = 7'h10,
    OP_STW  = 7'h11,
    OP_ADDI = 7'h20,
    OP_BEQ  = 7'h30,
    OP_NOP  = 7'h7F
  } opcode_e;

  // Control set handed to execute, 10 bits
  typedef struct packed {
    logic    branch;
    logic    reg_write;
    logic    mem_read;
    logic    mem_to_reg;
    alu_op_t alu_op;
    logic    mem_write;
    logic    alu_src;
    logic    is_imm;
    logic    illegal;
  } ctrl_t;

  // Fetch to decode, 65 bits
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } fetch_t;

  // Writeback port into the register file, 38 bits
  typedef struct packed {
    logic     en;
    reg_idx_t addr;
    word_t    data;
  } wb_t;

  // Decode to execute bundle
  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    instr;
    ctrl_t    ctrl;
    reg_idx_t dst;
    reg_idx_t src1;
    reg_idx_t src2;
    word_t    op_a;
    word_t    op_b;
    offset_t  offset;
  } decode_exec_t;

endpackage

// File: hw/instr_decoder.sv
/*
  Purely combinational opcode decoder, zero cycles.
  Unknown opcodes give all-zero control with illegal set.
  Fields are sliced whatever the opcode, execute picks what it needs.
*/

`timescale 1ns/1ps

module instr_decoder (
  input  decode_pkg::word_t    instr,
  output decode_pkg::ctrl_t    ctrl,
  output decode_pkg::reg_idx_t dst,
  output decode_pkg::reg_idx_t src1,
  output decode_pkg::reg_idx_t src2,
  output decode_pkg::offset_t  offset
);

  import decode_pkg::*;

  opcode_e opcode;

  // Top seven bits name the operation
  assign opcode = opcode_e'(instr[OPC_LSB +: OPC_W]);

  // Register fields sit at fixed positions
  assign dst  = instr[DST_LSB +: IDX_W];
  assign src1 = instr[SRC1_LSB +: IDX_W];
  assign src2 = instr[SRC2_LSB +: IDX_W];

  // Offset shares its upper bits with src2
  assign offset = offset_t'(instr[OFF_W-1:0]);

  always_comb
  begin
    // Start from a quiet control set, each class turns on its own bits
    ctrl = '0;
    case (opcode)
      OP_ADD:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      OP_SUB:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_SUB;
      end
      OP_MUL:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_MUL;
      end
      OP_ADDI:
      begin
        // Second operand comes from the offset
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.is_imm    = 1'b1;
      end
      OP_LDW:
      begin
        // Address is src1 plus offset, result from memory
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      OP_STW:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      OP_BEQ:
      begin
        // Compare by subtraction, execute tests for zero
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;
      end
      OP_NOP:
      begin
        ctrl = '0;
      end
      default:
      begin
        ctrl.illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: hw/register_file.sv
/*
  32 x 32-bit register file, two combinational reads, one write.
  Writes land on the rising edge; a same-cycle read sees wb data.
  Register zero reads zero and drops writes.
*/

`timescale 1ns/1ps

module register_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  decode_pkg::reg_idx_t rd_addr_a,
  input  decode_pkg::reg_idx_t rd_addr_b,
  input  decode_pkg::wb_t      wb,
  output decode_pkg::word_t    rd_a,
  output decode_pkg::word_t    rd_b
);

  import decode_pkg::*;

  word_t regs [NUM_REGS];
  logic  wr_hit;

  // A write to register zero is no write at all
  assign wr_hit = wb.en && (wb.addr != ZERO_REG);

  // Shared read path for both ports
  function automatic word_t read_port(input reg_idx_t addr);
    word_t val;
    if (addr == ZERO_REG)
      val = '0;
    else if (wr_hit && (wb.addr == addr))
      // Bypass the write that lands at this edge
      val = wb.data;
    else
      val = regs[addr];
    return val;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_hit)
    begin
      regs[wb.addr] <= wb.data;
    end
  end

  // Both ports read in the same cycle
  always_comb
  begin
    rd_a = read_port(rd_addr_a);
    rd_b = read_port(rd_addr_b);
  end

endmodule

// File: hw/decode_exec_reg.sv
/*
  Decode/execute pipeline register, one cycle.
  Priority is flush, then stall, then load. A bubble loads with zero ctrl.
  Fetch must hold its input while stall is high.
*/

`timescale 1ns/1ps

module decode_exec_reg (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall,
  input  logic                     flush,
  input  decode_pkg::fetch_t       fetch,
  input  decode_pkg::ctrl_t        ctrl,
  input  decode_pkg::reg_idx_t     dst,
  input  decode_pkg::reg_idx_t     src1,
  input  decode_pkg::reg_idx_t     src2,
  input  decode_pkg::offset_t      offset,
  input  decode_pkg::word_t        op_a,
  input  decode_pkg::word_t        op_b,
  output decode_pkg::decode_exec_t bundle
);

  import decode_pkg::*;

  decode_exec_t next;

  // Gather decoder and register file results into one word
  always_comb
  begin
    next.valid  = fetch.valid;
    next.pc     = fetch.pc;
    next.instr  = fetch.instr;
    // No side effects from a bubble
    next.ctrl   = fetch.valid ? ctrl : '0;
    next.dst    = dst;
    next.src1   = src1;
    next.src2   = src2;
    next.op_a   = op_a;
    next.op_b   = op_b;
    next.offset = offset;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bundle <= '0;
    end
    else if (flush)
    begin
      // Kill the slot, payload fields are left as they were
      bundle.valid <= 1'b0;
      bundle.ctrl  <= '0;
    end
    else if (!stall)
    begin
      bundle <= next;
    end
    // Stall with no flush keeps everything as it is
  end

endmodule

// File: hw/decode_stage.sv
/*
  Decode stage top, one cycle from fetch_in to exec_out.
  Stall and flush are plain levels from outside this stage.
  Writeback into the register file goes on even during a stall.
*/

`timescale 1ns/1ps

module decode_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  decode_pkg::fetch_t       fetch_in,
  input  decode_pkg::wb_t          wb_in,
  input  logic                     stall,
  input  logic                     flush,
  output decode_pkg::decode_exec_t exec_out
);

  import decode_pkg::*;

  // Decoder outputs
  ctrl_t    dec_ctrl;
  reg_idx_t dst;
  reg_idx_t src1;
  reg_idx_t src2;
  offset_t  offset;

  // Operand values from the register file
  word_t rd_a;
  word_t rd_b;

  // Opcode to control set and fields
  instr_decoder instr_decoder_inst (
    .instr  (fetch_in.instr),
    .ctrl   (dec_ctrl),
    .dst    (dst),
    .src1   (src1),
    .src2   (src2),
    .offset (offset)
  );

  // Reads run alongside the decoder on the same instruction
  register_file register_file_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (src1),
    .rd_addr_b (src2),
    .wb        (wb_in),
    .rd_a      (rd_a),
    .rd_b      (rd_b)
  );

  // Both results meet in the pipeline register
  decode_exec_reg decode_exec_reg_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .flush  (flush),
    .fetch  (fetch_in),
    .ctrl   (dec_ctrl),
    .dst    (dst),
    .src1   (src1),
    .src2   (src2),
    .offset (offset),
    .op_a   (rd_a),
    .op_b   (rd_b),
    .bundle (exec_out)
  );

endmodule

// File: test/decode_checks.svh
/*
  Compare tasks for the decode stage testbench, included in its module body.
  They use rec_tn, test_errs and err_count of the including module.
*/

// Book one mismatch against the running test and the run
task automatic count_mismatch();
  test_errs++;
  err_count++;
endtask

task automatic check_valid(input logic got, input logic exp, input string field);
  if (got !== exp)
  begin
    $display("MISMATCH at %0d ns: test %0d %s is %b, expected %b",
             $time, rec_tn, field, got, exp);
    count_mismatch();
  end
endtask

// Used for pc, instr, op_a and op_b
task automatic check_word(input word_t got, input word_t exp, input string field);
  if (got !== exp)
  begin
    $display("MISMATCH at %0d ns: test %0d %s is %h, expected %h",
             $time, rec_tn, field, got, exp);
    count_mismatch();
  end
endtask

task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string field);
  if (got !== exp)
  begin
    $display("MISMATCH at %0d ns: test %0d %s is r%0d, expected r%0d",
             $time, rec_tn, field, got, exp);
    count_mismatch();
  end
endtask

task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
  ctrl_t diff;
  diff = got ^ exp;
  if (got !== exp)
  begin
    // Differing bits in struct order, branch first and illegal last
    $display("MISMATCH at %0d ns: test %0d ctrl is %h, expected %h, bits %b differ",
             $time, rec_tn, got, exp, diff);
    count_mismatch();
  end
endtask

task automatic check_offset(input offset_t got, input offset_t exp);
  if (got !== exp)
  begin
    $display("MISMATCH at %0d ns: test %0d offset is %h, expected %h",
             $time, rec_tn, got, exp);
    count_mismatch();
  end
endtask

// File: test/tb_decode_stage.sv
/*
  Testbench for the decode stage. Replays test/decode_testdata.mem, one record
  per cycle, checks exec_out on the following falling edge, then flushes a
  valid bundle with stall held. Run from the project root.
*/

`timescale 1ns/1ps

module tb_decode_stage;

  import decode_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int SLACK_CYCLES = 20;
  // Words per record and room for records in the data file
  localparam int REC_W        = 20;
  localparam int MAX_RECS     = 64;

  // DUT signals
  logic         clk = 1'b0;
  logic         rst_n;
  fetch_t       fetch_in;
  wb_t          wb_in;
  logic         stall;
  logic         flush;
  decode_exec_t exec_out;

  // Raw data file contents, unused words stay all ones
  logic [31:0] tv_mem [REC_W*MAX_RECS];
  int          num_recs;
  logic        load_done;

  // Run totals and the running test
  int err_count;
  int test_errs;
  int tests_run;
  int tests_failed;

  // Record being applied
  int           rec_tn;
  logic         rec_chk;
  decode_exec_t exp_bundle;

  `include "decode_checks.svh"

  decode_stage decode_stage_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .fetch_in (fetch_in),
    .wb_in    (wb_in),
    .stall    (stall),
    .flush    (flush),
    .exec_out (exec_out)
  );

  initial
  begin
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Records end at the first test number left as all ones
  function automatic int count_records();
    int n;
    n = 0;
    while ((n < MAX_RECS) && (tv_mem[n*REC_W] !== 32'hFFFF_FFFF))
      n++;
    return n;
  endfunction

  function automatic int next_test_number(input int idx);
    int nxt;
    nxt = tv_mem[(idx + 1) * REC_W];
    return nxt;
  endfunction

  // Put one record on the DUT inputs and latch its expected bundle
  task automatic drive_record(input int idx);
    int b;
    b = idx * REC_W;
    rec_tn         = tv_mem[b];
    fetch_in.valid = tv_mem[b+1][0];
    fetch_in.pc    = tv_mem[b+2];
    fetch_in.instr = tv_mem[b+3];
    wb_in.en       = tv_mem[b+4][0];
    wb_in.addr     = tv_mem[b+5][4:0];
    wb_in.data     = tv_mem[b+6];
    stall          = tv_mem[b+7][0];
    flush          = tv_mem[b+8][0];
    rec_chk        = tv_mem[b+9][0];
    // Expected half of the line
    exp_bundle.valid  = tv_mem[b+10][0];
    exp_bundle.pc     = tv_mem[b+11];
    exp_bundle.instr  = tv_mem[b+12];
    exp_bundle.ctrl   = tv_mem[b+13][9:0];
    exp_bundle.dst    = tv_mem[b+14][4:0];
    exp_bundle.src1   = tv_mem[b+15][4:0];
    exp_bundle.src2   = tv_mem[b+16][4:0];
    exp_bundle.op_a   = tv_mem[b+17];
    exp_bundle.op_b   = tv_mem[b+18];
    exp_bundle.offset = tv_mem[b+19][14:0];
  endtask

  task automatic compare_bundle();
    check_valid(exec_out.valid, exp_bundle.valid, "valid");
    check_word(exec_out.pc, exp_bundle.pc, "pc");
    check_word(exec_out.instr, exp_bundle.instr, "instr");
    check_ctrl(exec_out.ctrl, exp_bundle.ctrl);
    check_idx(exec_out.dst, exp_bundle.dst, "dst");
    check_idx(exec_out.src1, exp_bundle.src1, "src1");
    check_idx(exec_out.src2, exp_bundle.src2, "src2");
    check_word(exec_out.op_a, exp_bundle.op_a, "op_a");
    check_word(exec_out.op_b, exp_bundle.op_b, "op_b");
    check_offset(exec_out.offset, exp_bundle.offset);
  endtask

  task automatic report_test();
    tests_run++;
    if (test_errs == 0)
      $display("Test %0d finished, all checks ok", rec_tn);
    else
    begin
      tests_failed++;
      $display("Test %0d finished with %0d mismatches", rec_tn, test_errs);
    end
    test_errs = 0;
  endtask

  // Load a valid branch, then flush it while stall is also high
  task automatic run_flush_under_stall();
    ctrl_t beq_ctrl;
    beq_ctrl        = '0;
    beq_ctrl.branch = 1'b1;
    beq_ctrl.alu_op = ALU_SUB;
    rec_tn          = rec_tn + 1;
    fetch_in.valid  = 1'b1;
    fetch_in.pc     = 32'h0000_0300;
    fetch_in.instr  = {OP_BEQ, 25'd0};
    wb_in           = '0;
    stall           = 1'b0;
    flush           = 1'b0;
    @(negedge clk);
    check_valid(exec_out.valid, 1'b1, "valid");
    check_ctrl(exec_out.ctrl, beq_ctrl);
    // Flush must win over stall and kill the held slot
    stall = 1'b1;
    flush = 1'b1;
    @(negedge clk);
    check_valid(exec_out.valid, 1'b0, "valid");
    check_ctrl(exec_out.ctrl, '0);
    stall = 1'b0;
    flush = 1'b0;
    report_test();
  endtask

  initial
  begin
    rst_n     = 1'b0;
    fetch_in  = '0;
    wb_in     = '0;
    stall     = 1'b0;
    flush     = 1'b0;
    err_count = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    rec_tn    = 0;
    rec_chk   = 1'b0;
    exp_bundle = '0;
    load_done = 1'b0;
    for (int i = 0; i < REC_W*MAX_RECS; i++)
      tv_mem[i] = '1;
    $readmemh("test/decode_testdata.mem", tv_mem);
    num_recs  = count_records();
    load_done = 1'b1;
    if (num_recs == 0)
    begin
      $display("No test records could be read from test/decode_testdata.mem");
      err_count++;
    end
    // Reset released on a falling edge together with the first record
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < num_recs; i++)
    begin
      drive_record(i);
      // One cycle through the pipeline register
      @(negedge clk);
      if (rec_chk)
        compare_bundle();
      if ((i == num_recs - 1) || (next_test_number(i) != rec_tn))
        report_test();
    end
    run_flush_under_stall();
    $display("Tests run %0d, failed %0d, mismatches %0d",
             tests_run, tests_failed, err_count);
    if ((err_count == 0) && (tests_failed == 0))
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog sized from the record count
  initial
  begin
    int limit_cycles;
    wait (load_done);
    limit_cycles = num_recs + RESET_CYCLES + SLACK_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    $display("Run timed out after %0d clock cycles before all records were checked",
             limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: test/decode_testdata.mem
// test fv pc instr | wb_en wb_addr wb_data | stall flush check |
// expected: valid pc instr ctrl dst src1 src2 op_a op_b offset
// 1: reset value held by a stall, then a bubble with no check
1 1 100 00308805  0 0 0         1 0 1  0 0   0        0   0 0 0  0        0        0
1 0 0   0         0 0 0         0 0 0  0 0   0        0   0 0 0  0        0        0
// 2: register writes under bubbles, last one goes to r0
2 0 0   0         1 1 1111      0 0 1  0 0   0        0   0 0 0  0        0        0
2 0 0   0         1 2 22220000  0 0 1  0 0   0        0   0 0 0  0        0        0
2 0 0   0         1 3 33333333  0 0 1  0 0   0        0   0 0 0  0        0        0
2 0 0   0         1 4 deadbeef  0 0 1  0 0   0        0   0 0 0  0        0        0
2 0 0   0         1 0 ffffffff  0 0 1  0 0   0        0   0 0 0  0        0        0
// 3: every opcode plus two undefined ones, operands from the writes above
3 1 100 00308805  0 0 0         0 0 1  1 100 00308805 100 3 1 2  1111     22220000 805
3 1 104 02419000  0 0 0         0 0 1  1 104 02419000 110 4 3 4  33333333 deadbeef 1000
3 1 108 045107ff  0 0 0         0 0 1  1 108 045107ff 120 5 2 1  22220000 1111     7ff
3 1 10c 4060fffc  0 0 0         0 0 1  1 10c 4060fffc 106 6 1 1f 1111     0        7ffc
3 1 110 20720008  0 0 0         0 0 1  1 110 20720008 1c4 7 4 0  deadbeef 0        8
3 1 114 22010c10  0 0 0         0 0 1  1 114 22010c10 c   0 2 3  22220000 33333333 c10
3 1 118 60008020  0 0 0         0 0 1  1 118 60008020 210 0 1 0  1111     0        20
3 1 11c fe219001  0 0 0         0 0 1  1 11c fe219001 0   2 3 4  33333333 deadbeef 1001
3 1 120 0a100000  0 0 0         0 0 1  1 120 0a100000 1   1 0 0  0        0        0
3 1 124 80000000  0 0 0         0 0 1  1 124 80000000 1   0 0 0  0        0        0
// 4: write-through in the same cycle, r0 stays zero
4 1 128 00942000  1 8 cafef00d  0 0 1  1 128 00942000 100 9 8 8  cafef00d cafef00d 2000
4 1 12c 02a02000  1 0 12345678  0 0 1  1 12c 02a02000 110 a 0 8  0        cafef00d 2000
4 1 130 00210400  1 1 0badc0de  0 0 1  1 130 00210400 100 2 2 1  22220000 0badc0de 400
// 5: stall holds the bundle, a write during the stall still lands
5 1 200 00308805  0 0 0         0 0 1  1 200 00308805 100 3 1 2  0badc0de 22220000 805
5 1 204 02419000  1 3 77777777  1 0 1  1 200 00308805 100 3 1 2  0badc0de 22220000 805
5 1 204 02419000  0 0 0         1 0 1  1 200 00308805 100 3 1 2  0badc0de 22220000 805
5 1 204 02419000  0 0 0         0 0 1  1 204 02419000 110 4 3 4  77777777 deadbeef 1000
// 6: flush keeps the payload but kills valid and ctrl, then bubble and recovery
6 1 208 20720008  0 0 0         0 1 1  0 204 02419000 0   4 3 4  77777777 deadbeef 1000
6 1 20c 22010c10  0 0 0         1 1 1  0 204 02419000 0   4 3 4  77777777 deadbeef 1000
6 0 210 4060fffc  0 0 0         0 0 1  0 210 4060fffc 0   6 1 1f 0badc0de 0        7ffc
6 1 214 60008020  0 0 0         0 0 1  1 214 60008020 210 0 1 0  0badc0de 0        20

// File: build.f
+incdir+test
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/decode_exec_reg.sv
hw/decode_stage.sv
test/tb_decode_stage.sv

// File: Makefile
# Verilator build and run for the decode stage testbench
# Run from the project root, the testbench reads test/decode_testdata.mem

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLAGS     ?= --binary --timing --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
